/* rtl/rayPkg.sv */
package rayPkg;

  // Signed fixed-point format used for all camera vectors, Q12.12
  localparam int QM = 12;
  localparam int QN = 12;
  localparam int FW = QM + QN;

  // Distance output takes bits 6 down to -9 around the binary point, giving UQ7.9
  localparam int DIST_MSB = 6;
  localparam int DIST_LSB = -9;

  // Texture column width, 64 columns per wall cell
  localparam int TEX_W = 6;

  // The first row ray is deflected by -272 view planes
  // The count is taken from the start of vertical back porch, one row early
  localparam int ADDEND_START = 272;

  // The deflection accumulates whole view planes, scaled back down by this shift
  localparam int ADDEND_SHIFT = 8;

  // Tracer FSM states
  typedef enum logic [2:0] {
    IDLE,
    RECIP_X,
    RECIP_Y,
    PREP,
    STEP,
    TEST,
    DONE
  } tracerState_t;

  // APB register map
  // Map cells follow MAP_BASE, one word per cell, row-major
  typedef enum logic [11:0] {
    ADDR_PLAYER_X = 12'h000,
    ADDR_PLAYER_Y = 12'h004,
    ADDR_FACING_X = 12'h008,
    ADDR_FACING_Y = 12'h00C,
    ADDR_VPLANE_X = 12'h010,
    ADDR_VPLANE_Y = 12'h014,
    MAP_BASE      = 12'h100
  } cfgAddr_t;

endpackage

/* rtl/fixedRecip.sv */
`timescale 1ns/1ns

module fixedRecip import rayPkg::*; (
  input  logic          clk,
  input  logic          i_arstN,
  input  logic          i_start,
  input  logic [FW-1:0] i_data,
  output logic          o_done,
  output logic [FW-1:0] o_data,
  output logic          o_sat
);

  localparam int CW = $clog2(FW + 1);
  localparam logic [FW-1:0] MAX_POS = {1'b0, {(FW-1){1'b1}}};

  logic [FW-1:0] absIn;
  logic [FW-1:0] divSel;
  logic [FW-1:0] divisor;
  logic [FW-1:0] rem;
  logic [FW:0]   trial;
  logic [FW:0]   remNext;
  logic [FW:0]   quot;
  logic [FW:0]   quotNext;
  logic          qBit;
  logic          busy;
  logic          lastIter;
  logic          overflow;
  logic [CW-1:0] count;

  // Magnitude of the operand, the most negative value maps to 2^(FW-1) unsigned
  assign absIn = i_data[FW-1] ? -i_data : i_data;

  // The start cycle already runs the first iteration straight from the input
  assign divSel = i_start ? absIn : divisor;

  // Dividend is 2^(2*QN), a single set bit at position FW
  // It enters on the first iteration, every later iteration shifts in a zero
  assign trial = i_start ? {{FW{1'b0}}, 1'b1} : {rem, 1'b0};
  assign qBit = trial >= {1'b0, divSel};
  assign remNext = qBit ? trial - {1'b0, divSel} : trial;
  assign quotNext = i_start ? {{FW{1'b0}}, qBit} : {quot[FW-1:0], qBit};

  // Last of the FW+1 iterations
  assign lastIter = busy && !i_start && (count == CW'(1));

  // Divide by zero, or a quotient too large for the signed format
  assign overflow = (divisor == '0) || (quotNext[FW:FW-1] != 2'b00);

  always_ff @(posedge clk or negedge i_arstN) begin
    if (!i_arstN) begin
      busy   <= 1'b0;
      count  <= '0;
      o_done <= 1'b0;
      o_sat  <= 1'b0;
      o_data <= '0;
    end else begin
      o_done <= lastIter;
      if (i_start) begin
        // A new start aborts any division in flight
        busy  <= 1'b1;
        count <= CW'(FW);
      end else if (busy) begin
        count <= count - 1'b1;
        if (lastIter) begin
          busy <= 1'b0;
        end
      end
      if (lastIter) begin
        o_data <= overflow ? MAX_POS : quotNext[FW-1:0];
        o_sat  <= overflow;
      end
    end
  end

  // Datapath of the divider
  always_ff @(posedge clk) begin
    if (i_start || busy) begin
      divisor <= divSel;
      rem     <= remNext[FW-1:0];
      quot    <= quotNext;
    end
  end

endmodule

/* rtl/tileMap.sv */
`timescale 1ns/1ns

module tileMap #(
  parameter int MAP_WIDTH_BITS  = 4,
  parameter int MAP_HEIGHT_BITS = 4
) (
  input  logic                       clk,
  input  logic                       i_arstN,
  input  logic                       i_wrEn,
  input  logic [MAP_WIDTH_BITS-1:0]  i_wrCol,
  input  logic [MAP_HEIGHT_BITS-1:0] i_wrRow,
  input  logic                       i_wrBit,
  input  logic [MAP_WIDTH_BITS-1:0]  i_rdCol,
  input  logic [MAP_HEIGHT_BITS-1:0] i_rdRow,
  output logic                       o_rdBit,
  input  logic [MAP_WIDTH_BITS-1:0]  i_traceCol,
  input  logic [MAP_HEIGHT_BITS-1:0] i_traceRow,
  output logic                       o_traceBit
);

  localparam int CELLS = 1 << (MAP_WIDTH_BITS + MAP_HEIGHT_BITS);

  // One bit per cell, set means wall
  // Cell index is the row followed by the column
  logic [CELLS-1:0] cells;

  // An empty map after reset gives the tracer a defined, if endless, walk
  always_ff @(posedge clk or negedge i_arstN) begin
    if (!i_arstN) begin
      cells <= '0;
    end else if (i_wrEn) begin
      cells[{i_wrRow, i_wrCol}] <= i_wrBit;
    end
  end

  // APB readback port
  assign o_rdBit = cells[{i_rdRow, i_rdCol}];

  // Tracer port, read in the same cycle as the cell address
  assign o_traceBit = cells[{i_traceRow, i_traceCol}];

endmodule

/* rtl/apbCfgRegs.sv */
`timescale 1ns/1ns

module apbCfgRegs import rayPkg::*; #(
  parameter int MAP_WIDTH_BITS  = 4,
  parameter int MAP_HEIGHT_BITS = 4
) (
  input  logic                       clk,
  input  logic                       i_arstN,
  input  logic                       i_psel,
  input  logic                       i_penable,
  input  logic                       i_pwrite,
  input  logic [11:0]                i_paddr,
  input  logic [31:0]                i_pwdata,
  output logic [31:0]                o_prdata,
  output logic                       o_pready,
  output logic                       o_pslverr,
  output logic [FW-1:0]              o_playerX,
  output logic [FW-1:0]              o_playerY,
  output logic [FW-1:0]              o_facingX,
  output logic [FW-1:0]              o_facingY,
  output logic [FW-1:0]              o_vplaneX,
  output logic [FW-1:0]              o_vplaneY,
  output logic                       o_mapWrEn,
  output logic [MAP_WIDTH_BITS-1:0]  o_mapCol,
  output logic [MAP_HEIGHT_BITS-1:0] o_mapRow,
  output logic                       o_mapWrBit,
  input  logic                       i_mapRdBit
);

  localparam int CELLS = 1 << (MAP_WIDTH_BITS + MAP_HEIGHT_BITS);

  logic          access;
  logic          regHit;
  logic          mapHit;
  logic [11:0]   mapOffset;
  logic [FW-1:0] rdVec;

  // Zero wait states, every access cycle completes
  assign o_pready = 1'b1;
  assign access = i_psel && i_penable;

  // Map window starts at MAP_BASE, word aligned, one word per cell
  assign mapOffset = i_paddr - MAP_BASE;
  assign mapHit = (i_paddr >= MAP_BASE) && (mapOffset[1:0] == 2'b00) &&
                  (mapOffset[11:2] < CELLS);
  assign o_mapCol = mapOffset[MAP_WIDTH_BITS+1:2];
  assign o_mapRow = mapOffset[MAP_WIDTH_BITS+MAP_HEIGHT_BITS+1:MAP_WIDTH_BITS+2];
  assign o_mapWrBit = i_pwdata[0];
  assign o_mapWrEn = access && i_pwrite && mapHit;

  // Vector register decode and readback select
  always_comb begin
    regHit = 1'b1;
    rdVec  = '0;
    case (i_paddr)
      ADDR_PLAYER_X: rdVec = o_playerX;
      ADDR_PLAYER_Y: rdVec = o_playerY;
      ADDR_FACING_X: rdVec = o_facingX;
      ADDR_FACING_Y: rdVec = o_facingY;
      ADDR_VPLANE_X: rdVec = o_vplaneX;
      ADDR_VPLANE_Y: rdVec = o_vplaneY;
      default:       regHit = 1'b0;
    endcase
  end

  // Vectors read back sign-extended, map cells in bit 0, anything else as zero
  assign o_prdata = regHit ? {{(32-FW){rdVec[FW-1]}}, rdVec} :
                    mapHit ? {31'b0, i_mapRdBit} : 32'b0;
  assign o_pslverr = access && !regHit && !mapHit;

  always_ff @(posedge clk or negedge i_arstN) begin
    if (!i_arstN) begin
      o_playerX <= '0;
      o_playerY <= '0;
      o_facingX <= '0;
      o_facingY <= '0;
      o_vplaneX <= '0;
      o_vplaneY <= '0;
    end else if (access && i_pwrite) begin
      case (i_paddr)
        ADDR_PLAYER_X: o_playerX <= i_pwdata[FW-1:0];
        ADDR_PLAYER_Y: o_playerY <= i_pwdata[FW-1:0];
        ADDR_FACING_X: o_facingX <= i_pwdata[FW-1:0];
        ADDR_FACING_Y: o_facingY <= i_pwdata[FW-1:0];
        ADDR_VPLANE_X: o_vplaneX <= i_pwdata[FW-1:0];
        ADDR_VPLANE_Y: o_vplaneY <= i_pwdata[FW-1:0];
        default: ;
      endcase
    end
  end

endmodule

/* rtl/wallTracer.sv */
`timescale 1ns/1ns

module wallTracer import rayPkg::*; #(
  parameter int MAP_WIDTH_BITS  = 4,
  parameter int MAP_HEIGHT_BITS = 4
) (
  input  logic                       clk,
  input  logic                       i_arstN,
  input  logic                       i_vsync,
  input  logic                       i_hmax,
  input  logic signed [FW-1:0]       i_playerX,
  input  logic signed [FW-1:0]       i_playerY,
  input  logic signed [FW-1:0]       i_facingX,
  input  logic signed [FW-1:0]       i_facingY,
  input  logic signed [FW-1:0]       i_vplaneX,
  input  logic signed [FW-1:0]       i_vplaneY,
  output logic [MAP_WIDTH_BITS-1:0]  o_mapCol,
  output logic [MAP_HEIGHT_BITS-1:0] o_mapRow,
  input  logic                       i_mapVal,
  output logic                       o_recipStart,
  output logic [FW-1:0]              o_recipData,
  input  logic                       i_recipDone,
  input  logic [FW-1:0]              i_recipData,
  input  logic                       i_recipSat,
  output logic                       o_lineReady,
  output logic                       o_resultValid,
  output logic                       o_side,
  output logic [15:0]                o_vdist,
  output logic [TEX_W-1:0]           o_tex
);

  localparam logic [FW-1:0] ONE = FW'(1) << QN;
  localparam logic [FW-1:0] MAX_STEP = {1'b0, {(FW-1){1'b1}}};

  tracerState_t state;
  logic vsyncQ;

  // Camera vectors as copied during vertical blanking
  logic signed [FW-1:0] playerX;
  logic signed [FW-1:0] playerY;
  logic signed [FW-1:0] facingX;
  logic signed [FW-1:0] facingY;
  logic signed [FW-1:0] vplaneX;
  logic signed [FW-1:0] vplaneY;

  // Deflection from the facing vector, accumulating one view plane per row
  logic signed [FW-1:0] rayAddendX;
  logic signed [FW-1:0] rayAddendY;
  logic signed [FW-1:0] rayDirX;
  logic signed [FW-1:0] rayDirY;
  logic rxi;
  logic ryi;

  // Track distances are unsigned so that a huge step added once still compares larger
  logic [FW-1:0] stepDistX;
  logic [FW-1:0] stepDistY;
  logic [FW-1:0] trackDistX;
  logic [FW-1:0] trackDistY;
  logic [FW-1:0] partialX;
  logic [FW-1:0] partialY;
  logic [FW-1:0] recipStep;
  logic [2*FW-1:0] trackInitX;
  logic [2*FW-1:0] trackInitY;

  logic [QM-1:0] mapX;
  logic [QM-1:0] mapY;
  logic side;
  logic needStepX;

  logic [FW-1:0] visualDist;
  logic signed [2*FW-1:0] hitProd;
  logic [FW-1:0] wallPartial;

  assign rayDirX = facingX + (rayAddendX >>> ADDEND_SHIFT);
  assign rayDirY = facingY + (rayAddendY >>> ADDEND_SHIFT);
  assign rxi = rayDirX > 0;
  assign ryi = rayDirY > 0;

  // One divider serves both axes, picked by state
  assign o_recipData = (state == RECIP_Y) ? rayDirY : rayDirX;
  assign recipStep = i_recipSat ? MAX_STEP : i_recipData;

  // Distance to the first gridline, a zero fraction moving down gives zero
  assign partialX = rxi ? ONE - {{QM{1'b0}}, playerX[QN-1:0]} : {{QM{1'b0}}, playerX[QN-1:0]};
  assign partialY = ryi ? ONE - {{QM{1'b0}}, playerY[QN-1:0]} : {{QM{1'b0}}, playerY[QN-1:0]};
  assign trackInitX = stepDistX * partialX;
  assign trackInitY = stepDistY * partialY;

  // Ties step along X
  assign needStepX = trackDistX <= trackDistY;

  assign o_mapCol = mapX[MAP_WIDTH_BITS-1:0];
  assign o_mapRow = mapY[MAP_HEIGHT_BITS-1:0];
  assign o_lineReady = (state == DONE);

  // The last step overshoots by one step distance, so it is taken back off
  assign visualDist = side ? trackDistY - stepDistY : trackDistX - stepDistX;

  // Hit point along the wall uses the ray component of the other axis
  assign hitProd = $signed(visualDist) * (side ? rayDirX : rayDirY);
  assign wallPartial = side ? playerX + hitProd[FW+QN-1:QN] : playerY + hitProd[FW+QN-1:QN];

  always_ff @(posedge clk or negedge i_arstN) begin
    if (!i_arstN) begin
      state         <= IDLE;
      vsyncQ        <= 1'b0;
      o_recipStart  <= 1'b0;
      o_resultValid <= 1'b0;
      o_side        <= 1'b0;
      o_vdist       <= '0;
      o_tex         <= '0;
    end else begin
      vsyncQ        <= i_vsync;
      o_recipStart  <= 1'b0;
      o_resultValid <= 1'b0;
      if (i_vsync) begin
        state <= IDLE;
      end else begin
        case (state)
          // Leave only right after vsync falls, so the vectors are valid
          IDLE: if (vsyncQ) begin
            state        <= RECIP_X;
            o_recipStart <= 1'b1;
          end
          RECIP_X: if (i_recipDone) begin
            state        <= RECIP_Y;
            o_recipStart <= 1'b1;
          end
          RECIP_Y: if (i_recipDone) begin
            state <= PREP;
          end
          PREP: state <= STEP;
          STEP: state <= TEST;
          // Map cell of the last step is read back combinationally here
          TEST: state <= i_mapVal ? DONE : STEP;
          // Hold the finished trace until the row boundary
          DONE: if (i_hmax) begin
            o_side        <= side;
            o_vdist       <= visualDist[QN+DIST_MSB:QN+DIST_LSB];
            o_tex         <= wallPartial[QN-1 -: TEX_W];
            o_resultValid <= 1'b1;
            o_recipStart  <= 1'b1;
            state         <= RECIP_X;
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  // Ray datapath
  always_ff @(posedge clk) begin
    if (i_vsync) begin
      playerX    <= i_playerX;
      playerY    <= i_playerY;
      facingX    <= i_facingX;
      facingY    <= i_facingY;
      vplaneX    <= i_vplaneX;
      vplaneY    <= i_vplaneY;
      rayAddendX <= FW'(-(i_vplaneX * ADDEND_START));
      rayAddendY <= FW'(-(i_vplaneY * ADDEND_START));
      side       <= 1'b0;
    end else begin
      case (state)
        RECIP_X: if (i_recipDone) stepDistX <= recipStep;
        RECIP_Y: if (i_recipDone) stepDistY <= recipStep;
        PREP: begin
          mapX       <= playerX[FW-1:QN];
          mapY       <= playerY[FW-1:QN];
          trackDistX <= trackInitX[FW+QN-1:QN];
          trackDistY <= trackInitY[FW+QN-1:QN];
        end
        STEP: begin
          if (needStepX) begin
            mapX       <= rxi ? mapX + 1'b1 : mapX - 1'b1;
            trackDistX <= trackDistX + stepDistX;
            side       <= 1'b0;
          end else begin
            mapY       <= ryi ? mapY + 1'b1 : mapY - 1'b1;
            trackDistY <= trackDistY + stepDistY;
            side       <= 1'b1;
          end
        end
        DONE: if (i_hmax) begin
          rayAddendX <= rayAddendX + vplaneX;
          rayAddendY <= rayAddendY + vplaneY;
        end
        default: ;
      endcase
    end
  end

endmodule

/* rtl/rayCasterTop.sv */
`timescale 1ns/1ns

module rayCasterTop import rayPkg::*; #(
  parameter int MAP_WIDTH_BITS  = 4,
  parameter int MAP_HEIGHT_BITS = 4
) (
  input  logic             clk,
  input  logic             i_arstN,
  input  logic             i_psel,
  input  logic             i_penable,
  input  logic             i_pwrite,
  input  logic [11:0]      i_paddr,
  input  logic [31:0]      i_pwdata,
  output logic [31:0]      o_prdata,
  output logic             o_pready,
  output logic             o_pslverr,
  input  logic             i_vsync,
  input  logic             i_hmax,
  output logic             o_lineReady,
  output logic             o_resultValid,
  output logic             o_side,
  output logic [15:0]      o_vdist,
  output logic [TEX_W-1:0] o_tex
);

  logic [FW-1:0] playerX;
  logic [FW-1:0] playerY;
  logic [FW-1:0] facingX;
  logic [FW-1:0] facingY;
  logic [FW-1:0] vplaneX;
  logic [FW-1:0] vplaneY;

  // APB side of the map
  logic                       mapWrEn;
  logic [MAP_WIDTH_BITS-1:0]  mapCol;
  logic [MAP_HEIGHT_BITS-1:0] mapRow;
  logic                       mapWrBit;
  logic                       mapRdBit;

  // Tracer side of the map
  logic [MAP_WIDTH_BITS-1:0]  traceCol;
  logic [MAP_HEIGHT_BITS-1:0] traceRow;
  logic                       traceBit;

  // Shared reciprocal unit
  logic          recipStart;
  logic [FW-1:0] recipOp;
  logic          recipDone;
  logic [FW-1:0] recipRes;
  logic          recipSat;

  apbCfgRegs #(
    .MAP_WIDTH_BITS (MAP_WIDTH_BITS),
    .MAP_HEIGHT_BITS(MAP_HEIGHT_BITS)
  ) uRegs (
    .clk       (clk),
    .i_arstN   (i_arstN),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_prdata  (o_prdata),
    .o_pready  (o_pready),
    .o_pslverr (o_pslverr),
    .o_playerX (playerX),
    .o_playerY (playerY),
    .o_facingX (facingX),
    .o_facingY (facingY),
    .o_vplaneX (vplaneX),
    .o_vplaneY (vplaneY),
    .o_mapWrEn (mapWrEn),
    .o_mapCol  (mapCol),
    .o_mapRow  (mapRow),
    .o_mapWrBit(mapWrBit),
    .i_mapRdBit(mapRdBit)
  );

  // The APB cell address serves both the write and the readback port
  tileMap #(
    .MAP_WIDTH_BITS (MAP_WIDTH_BITS),
    .MAP_HEIGHT_BITS(MAP_HEIGHT_BITS)
  ) uMap (
    .clk       (clk),
    .i_arstN   (i_arstN),
    .i_wrEn    (mapWrEn),
    .i_wrCol   (mapCol),
    .i_wrRow   (mapRow),
    .i_wrBit   (mapWrBit),
    .i_rdCol   (mapCol),
    .i_rdRow   (mapRow),
    .o_rdBit   (mapRdBit),
    .i_traceCol(traceCol),
    .i_traceRow(traceRow),
    .o_traceBit(traceBit)
  );

  fixedRecip uRecip (
    .clk    (clk),
    .i_arstN(i_arstN),
    .i_start(recipStart),
    .i_data (recipOp),
    .o_done (recipDone),
    .o_data (recipRes),
    .o_sat  (recipSat)
  );

  wallTracer #(
    .MAP_WIDTH_BITS (MAP_WIDTH_BITS),
    .MAP_HEIGHT_BITS(MAP_HEIGHT_BITS)
  ) uTracer (
    .clk          (clk),
    .i_arstN      (i_arstN),
    .i_vsync      (i_vsync),
    .i_hmax       (i_hmax),
    .i_playerX    (playerX),
    .i_playerY    (playerY),
    .i_facingX    (facingX),
    .i_facingY    (facingY),
    .i_vplaneX    (vplaneX),
    .i_vplaneY    (vplaneY),
    .o_mapCol     (traceCol),
    .o_mapRow     (traceRow),
    .i_mapVal     (traceBit),
    .o_recipStart (recipStart),
    .o_recipData  (recipOp),
    .i_recipDone  (recipDone),
    .i_recipData  (recipRes),
    .i_recipSat   (recipSat),
    .o_lineReady  (o_lineReady),
    .o_resultValid(o_resultValid),
    .o_side       (o_side),
    .o_vdist      (o_vdist),
    .o_tex        (o_tex)
  );

endmodule

/* test/rayCasterTop_chk.sv */
`timescale 1ns/1ns

module rayCasterTop_chk (
  input logic clk,
  input logic i_arstN,
  input logic i_psel,
  input logic i_penable,
  input logic i_hmax,
  input logic o_lineReady,
  input logic o_resultValid,
  input logic o_pready,
  input logic o_pslverr
);

  // A result only follows an hmax that found a finished trace
  resultAfterHmax: assert property (@(posedge clk) disable iff (!i_arstN)
    o_resultValid |-> $past(i_hmax && o_lineReady))
    else $error("o_resultValid rose without an hmax in DONE");

  // Zero wait states on APB
  readyAlwaysHigh: assert property (@(posedge clk) disable iff (!i_arstN) o_pready)
    else $error("PREADY dropped low");

  // Error response belongs to the access phase only
  errInAccess: assert property (@(posedge clk) disable iff (!i_arstN)
    o_pslverr |-> (i_psel && i_penable))
    else $error("PSLVERR high outside an access cycle");

endmodule

bind rayCasterTop rayCasterTop_chk rayCasterTop_chkInst (.*);

/* test/rayCasterTb.sv */
`timescale 1ns/1ns

module rayCasterTb import rayPkg::*; ();

  localparam longint MASK = 64'hFF_FFFF;
  localparam longint MAXP = 64'h7F_FFFF;

  logic        clk;
  logic        arstN;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        vsync;
  logic        hmax;
  logic        lineReady;
  logic        resultValid;
  logic        side;
  logic [15:0] vdist;
  logic [5:0]  tex;

  // Reference copy of the map and of the camera vectors as raw 24-bit words
  bit     mapModel [256];
  longint mPx, mPy, mFx, mFy, mVx, mVy, mAx, mAy;
  int     pCol, pRow;
  int     errors = 0;
  int     testErrs = 0;
  int     testsFailed = 0;

  rayCasterTop #(.MAP_WIDTH_BITS(4), .MAP_HEIGHT_BITS(4)) rayCasterTop_inst (
    .clk(clk), .i_arstN(arstN), .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
    .i_paddr(paddr), .i_pwdata(pwdata), .o_prdata(prdata), .o_pready(pready),
    .o_pslverr(pslverr), .i_vsync(vsync), .i_hmax(hmax), .o_lineReady(lineReady),
    .o_resultValid(resultValid), .o_side(side), .o_vdist(vdist), .o_tex(tex)
  );

  always #5 clk = ~clk;

  task automatic timeoutFail(input string what);
    $display("Timeout while waiting for %s at %0t", what, $time);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  // Hard limit on the whole run, well above the sum of all waits
  initial begin
    #2000000;
    timeoutFail("the end of the whole run");
  end

  task automatic checkEq(input string name, input longint got, input longint exp);
    assert (got == exp) else begin
      $display("MISMATCH t=%0t %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic longint sext24(input longint v);
    longint m;
    m = v & MASK;
    if (m >= 64'h80_0000) return m - 64'h100_0000;
    return m;
  endfunction

  // 2^24 over the magnitude, saturating when it does not fit below 2^23
  function automatic longint recipModel(input longint d);
    longint a;
    longint q;
    a = sext24(d);
    if (a < 0) a = -a;
    if (a == 0) return MAXP;
    q = 64'h100_0000 / a;
    if (q >= 64'h80_0000) return MAXP;
    return q;
  endfunction

  // One APB transfer, setup then access, sampled inside the access cycle
  task automatic apbXfer(input bit wr, input int addr, input longint wdata,
                         output logic [31:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = 12'(addr);
    pwdata  = 32'(wdata);
    @(negedge clk);
    penable = 1'b1;
    #1;
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic writeCell(input int idx, input bit b);
    logic [31:0] rd;
    logic err;
    apbXfer(1'b1, int'(MAP_BASE) + 4 * idx, longint'(b), rd, err);
    checkEq("o_pslverr", err, 0);
    mapModel[idx] = b;
  endtask

  // Border walls, sparse random walls, and the player cell kept free
  task automatic buildScene();
    bit wall;
    pCol = 1 + int'($urandom % 14);
    pRow = 1 + int'($urandom % 14);
    for (int r = 0; r < 16; r++) begin
      for (int c = 0; c < 16; c++) begin
        wall = (r == 0) || (r == 15) || (c == 0) || (c == 15) || ($urandom % 6 == 0);
        if (r == pRow && c == pCol) wall = 1'b0;
        writeCell(r * 16 + c, wall);
      end
    end
  endtask

  // Vectors may only change while vsync is high
  task automatic setVectors();
    logic [31:0] rd;
    logic err;
    mPx = ((longint'(pCol) << 12) | longint'($urandom % 4096)) & MASK;
    mPy = ((longint'(pRow) << 12) | longint'($urandom % 4096)) & MASK;
    mFx = (longint'($urandom % 8193) - 4096) & MASK;
    mFy = (longint'($urandom % 8193) - 4096) & MASK;
    mVx = (longint'($urandom % 1025) - 512) & MASK;
    mVy = (longint'($urandom % 1025) - 512) & MASK;
    apbXfer(1'b1, int'(ADDR_PLAYER_X), mPx, rd, err);
    apbXfer(1'b1, int'(ADDR_PLAYER_Y), mPy, rd, err);
    apbXfer(1'b1, int'(ADDR_FACING_X), mFx, rd, err);
    apbXfer(1'b1, int'(ADDR_FACING_Y), mFy, rd, err);
    apbXfer(1'b1, int'(ADDR_VPLANE_X), mVx, rd, err);
    apbXfer(1'b1, int'(ADDR_VPLANE_Y), mVy, rd, err);
  endtask

  task automatic startFrame();
    @(negedge clk);
    vsync = 1'b0;
    mAx = (-(sext24(mVx) * 272)) & MASK;
    mAy = (-(sext24(mVy) * 272)) & MASK;
  endtask

  task automatic enterBlank();
    @(negedge clk);
    vsync = 1'b1;
  endtask

  // Grid walk of one ray from the current deflection
  task automatic modelRow(output bit eSide, output longint eDist, output longint eTex);
    longint rdx, rdy, sdx, sdy, tdx, tdy, mx, my, vd, prod, wp;
    bit rxi, ryi;
    rdx = sext24(mFx + (sext24(mAx) >>> 8));
    rdy = sext24(mFy + (sext24(mAy) >>> 8));
    sdx = recipModel(rdx);
    sdy = recipModel(rdy);
    rxi = rdx > 0;
    ryi = rdy > 0;
    tdx = ((sdx * (rxi ? 4096 - (mPx & 4095) : (mPx & 4095))) >> 12) & MASK;
    tdy = ((sdy * (ryi ? 4096 - (mPy & 4095) : (mPy & 4095))) >> 12) & MASK;
    mx = (mPx >> 12) & 4095;
    my = (mPy >> 12) & 4095;
    eSide = 1'b0;
    for (int i = 0; i < 200; i++) begin
      if (tdx <= tdy) begin
        mx = (mx + (rxi ? 1 : -1)) & 4095;
        tdx = (tdx + sdx) & MASK;
        eSide = 1'b0;
      end else begin
        my = (my + (ryi ? 1 : -1)) & 4095;
        tdy = (tdy + sdy) & MASK;
        eSide = 1'b1;
      end
      if (mapModel[(my & 15) * 16 + (mx & 15)]) break;
    end
    vd = eSide ? (tdy - sdy) & MASK : (tdx - sdx) & MASK;
    eDist = (vd >> 3) & 16'hFFFF;
    prod = sext24(vd) * (eSide ? rdx : rdy);
    wp = ((eSide ? mPx : mPy) + ((prod >>> 12) & MASK)) & MASK;
    eTex = (wp >> 6) & 63;
  endtask

  task automatic waitLineReady();
    int n;
    n = 0;
    while (!lineReady) begin
      n++;
      if (n > 400) timeoutFail("o_lineReady");
      @(negedge clk);
    end
  endtask

  // Request one row at the next hmax and compare it with the model
  task automatic runRow();
    int n;
    bit eSide;
    longint eDist, eTex;
    waitLineReady();
    hmax = 1'b1;
    @(negedge clk);
    hmax = 1'b0;
    n = 0;
    while (!resultValid) begin
      n++;
      if (n > 4) timeoutFail("o_resultValid");
      @(negedge clk);
    end
    modelRow(eSide, eDist, eTex);
    checkEq("o_side", side, eSide);
    checkEq("o_vdist", vdist, eDist);
    checkEq("o_tex", tex, eTex);
    // The next row is already being traced
    checkEq("o_lineReady", lineReady, 0);
    mAx = (mAx + mVx) & MASK;
    mAy = (mAy + mVy) & MASK;
  endtask

  task automatic endTest(input int num, input string name);
    if (errors == testErrs) begin
      $display("Test %0d %s: ok", num, name);
    end else begin
      $display("Test %0d %s: %0d failed checks", num, name, errors - testErrs);
      testsFailed++;
    end
    testErrs = errors;
  endtask

  initial begin
    logic [31:0] rd;
    logic err;
    longint vals [6];
    int cells [20];
    logic prevSide;
    logic [15:0] prevDist;
    logic [5:0] prevTex;
    void'($urandom(32'he9d3_28be));
    clk = 1'b0;
    arstN = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    vsync = 1'b1;
    hmax = 1'b0;
    repeat (4) @(negedge clk);
    // Outputs while reset is still applied
    checkEq("o_lineReady", lineReady, 0);
    checkEq("o_resultValid", resultValid, 0);
    checkEq("o_pslverr", pslverr, 0);
    checkEq("o_side", side, 0);
    checkEq("o_vdist", vdist, 0);
    checkEq("o_tex", tex, 0);
    arstN = 1'b1;

    // Vector registers and the unmapped hole after them
    for (int i = 0; i < 6; i++) begin
      vals[i] = longint'($urandom);
      apbXfer(1'b1, 4 * i, vals[i], rd, err);
      checkEq("o_pslverr", err, 0);
    end
    // A write to the hole must leave every vector untouched
    apbXfer(1'b1, 12'h020, 64'h1234, rd, err);
    assert (err) else begin
      $display("Write to unmapped address 0x020 gave no PSLVERR");
      errors++;
    end
    for (int i = 0; i < 6; i++) begin
      apbXfer(1'b0, 4 * i, 0, rd, err);
      checkEq("o_prdata", rd, (sext24(vals[i]) & 64'hFFFF_FFFF));
      checkEq("o_pslverr", err, 0);
    end
    apbXfer(1'b0, 12'h020, 0, rd, err);
    assert (err) else begin
      $display("Read from unmapped address 0x020 gave no PSLVERR");
      errors++;
    end
    checkEq("o_prdata", rd, 0);
    endTest(1, "register readback");

    for (int i = 0; i < 20; i++) begin
      cells[i] = int'($urandom % 256);
      writeCell(cells[i], 1'($urandom % 2));
    end
    for (int i = 0; i < 20; i++) begin
      apbXfer(1'b0, int'(MAP_BASE) + 4 * cells[i], 0, rd, err);
      checkEq("o_prdata", rd, longint'(mapModel[cells[i]]));
      checkEq("o_pslverr", err, 0);
    end
    endTest(2, "map readback");

    buildScene();
    setVectors();
    startFrame();
    runRow();
    endTest(3, "single row trace");

    enterBlank();
    buildScene();
    setVectors();
    startFrame();
    repeat (20) runRow();
    endTest(4, "multi row frame");

    enterBlank();
    setVectors();
    prevSide = side;
    prevDist = vdist;
    prevTex = tex;
    startFrame();
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      assert (!lineReady) else begin
        $display("Trace finished early, hmax during tracing could not be tested");
        errors++;
      end
      hmax = 1'b1;
      @(negedge clk);
      hmax = 1'b0;
      checkEq("o_resultValid", resultValid, 0);
      checkEq("o_side", side, prevSide);
      checkEq("o_vdist", vdist, prevDist);
      checkEq("o_tex", tex, prevTex);
    end
    runRow();
    endTest(5, "ignored hmax");

    repeat (3) runRow();
    // Blank while the next row is still being traced
    enterBlank();
    setVectors();
    startFrame();
    repeat (2) runRow();
    endTest(6, "mid-frame vsync");

    $display("Tests run 6, tests failed %0d, checks failed %0d", testsFailed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* rayCasterTop.f */
rtl/rayPkg.sv
rtl/fixedRecip.sv
rtl/tileMap.sv
rtl/apbCfgRegs.sv
rtl/wallTracer.sv
rtl/rayCasterTop.sv
test/rayCasterTop_chk.sv
test/rayCasterTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the ray caster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module rayCasterTb -Mdir obj_dir -o simTb -f rayCasterTop.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/simTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
